// ==== Bender.yml ====
package:
  name: i2c_subsystem

sources:
  - i2c_pkg.sv
  - i2c_cmd_fifo.sv
  - i2c_init_sequencer.sv
  - i2c_bus_master.sv
  - i2c_subsystem.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - i2c_target_model.sv
      - tb_i2c_subsystem.sv

// ==== i2c_bus_master.sv ====
`timescale 1ns/1ns

module i2c_bus_master #(
  parameter int SCL_DIV = 4
) (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              empty_i,
  input  i2c_pkg::i2c_cmd_t cmd_i,
  output logic              pop_o,
  output logic              xfer_done_o,
  output logic              nack_o,
  output logic [7:0]        rd_data_o,
  input  logic              scl1_i,
  input  logic              sda1_i,
  input  logic              scl2_i,
  input  logic              sda2_i,
  output logic              scl1_oe_o,
  output logic              sda1_oe_o,
  output logic              scl2_oe_o,
  output logic              sda2_oe_o
);

  localparam int DIV_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

  // Byte slots within one transfer
  localparam logic [2:0] BYTE_ADDR_W = 3'd0;
  localparam logic [2:0] BYTE_REG    = 3'd1;
  localparam logic [2:0] BYTE_DATA   = 3'd2;
  localparam logic [2:0] BYTE_ADDR_R = 3'd3;
  localparam logic [2:0] BYTE_READ   = 3'd4;

  i2c_pkg::bus_state_e state_q;
  i2c_pkg::i2c_cmd_t   cmd_q;
  logic [DIV_W-1:0]    div_q;
  logic                tick;     // One per quarter SCL period
  logic [1:0]          qtr_q;
  logic [2:0]          bit_q;
  logic [2:0]          slot_q;
  logic [7:0]          tx_byte;
  logic                scl_low;
  logic                scl_in;
  logic                sda_in;
  logic                scl_oe_c;
  logic                sda_oe_c;
  logic                scl_oe_q;
  logic                sda_oe_q;

  assign tick    = (div_q == DIV_W'(SCL_DIV - 1));
  assign pop_o   = (state_q == i2c_pkg::BS_IDLE) && !empty_i;
  assign scl_low = (qtr_q == 2'd0) || (qtr_q == 2'd3);

  // Selected bus
  assign scl_in = cmd_q.bus_sel ? scl2_i : scl1_i;
  assign sda_in = cmd_q.bus_sel ? sda2_i : sda1_i;

  always_comb begin
    case (slot_q)
      BYTE_ADDR_W: tx_byte = {cmd_q.dev_addr, 1'b0};
      BYTE_REG:    tx_byte = cmd_q.reg_addr;
      BYTE_DATA:   tx_byte = cmd_q.wdata;
      BYTE_ADDR_R: tx_byte = {cmd_q.dev_addr, 1'b1};
      default:     tx_byte = 8'hff;  // Read byte leaves SDA to the target
    endcase
  end

  //////////////////////////////////////////////////////////////
  // Line drive per quarter

  always_comb begin
    scl_oe_c = 1'b0;
    sda_oe_c = 1'b0;
    case (state_q)
      i2c_pkg::BS_START: begin
        sda_oe_c = (qtr_q != 2'd0);      // SDA falls with SCL high
        scl_oe_c = (qtr_q == 2'd3);
      end
      i2c_pkg::BS_RESTART: begin
        sda_oe_c = qtr_q[1];
        scl_oe_c = scl_low;
      end
      i2c_pkg::BS_BYTE: begin
        sda_oe_c = !tx_byte[bit_q];
        scl_oe_c = scl_low;
      end
      i2c_pkg::BS_ACK: begin
        scl_oe_c = scl_low;              // Master NACK on reads by release
      end
      i2c_pkg::BS_STOP: begin
        sda_oe_c = !qtr_q[1];            // SDA rises with SCL high
        scl_oe_c = (qtr_q == 2'd0);
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////
  // Bus FSM

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q     <= i2c_pkg::BS_IDLE;
      div_q       <= '0;
      qtr_q       <= '0;
      bit_q       <= '0;
      slot_q      <= '0;
      nack_o      <= 1'b0;
      xfer_done_o <= 1'b0;
      scl_oe_q    <= 1'b0;
      sda_oe_q    <= 1'b0;
    end else begin
      xfer_done_o <= 1'b0;
      scl_oe_q    <= scl_oe_c;
      sda_oe_q    <= sda_oe_c;
      div_q <= (state_q == i2c_pkg::BS_IDLE || tick) ? '0 : div_q + DIV_W'(1);

      if (state_q == i2c_pkg::BS_IDLE) begin
        qtr_q <= '0;
        if (pop_o) begin
          nack_o  <= 1'b0;
          slot_q  <= BYTE_ADDR_W;
          state_q <= i2c_pkg::BS_START;
        end
      end else if (tick) begin
        qtr_q <= qtr_q + 2'd1;
        // ACK sampled mid high; a held SCL counts as no ACK too
        if (state_q == i2c_pkg::BS_ACK && qtr_q == 2'd2 && slot_q != BYTE_READ &&
            (sda_in || !scl_in)) begin
          nack_o <= 1'b1;
        end
        if (qtr_q == 2'd3) begin
          case (state_q)
            i2c_pkg::BS_START, i2c_pkg::BS_RESTART: begin
              bit_q   <= 3'd7;
              state_q <= i2c_pkg::BS_BYTE;
            end
            i2c_pkg::BS_BYTE: begin
              if (bit_q == 3'd0) state_q <= i2c_pkg::BS_ACK;
              else bit_q <= bit_q - 3'd1;
            end
            i2c_pkg::BS_ACK: begin
              if (nack_o || slot_q == BYTE_DATA || slot_q == BYTE_READ) begin
                state_q <= i2c_pkg::BS_STOP;
              end else if (slot_q == BYTE_REG && cmd_q.op == i2c_pkg::OP_READ) begin
                slot_q  <= BYTE_ADDR_R;
                state_q <= i2c_pkg::BS_RESTART;
              end else begin
                slot_q  <= slot_q + 3'd1;
                bit_q   <= 3'd7;
                state_q <= i2c_pkg::BS_BYTE;
              end
            end
            i2c_pkg::BS_STOP: begin
              xfer_done_o <= 1'b1;
              state_q     <= i2c_pkg::BS_IDLE;
            end
            default: state_q <= i2c_pkg::BS_IDLE;
          endcase
        end
      end
    end
  end

  // Command and read shift register
  always_ff @(posedge clk) begin
    if (pop_o) cmd_q <= cmd_i;
    if (tick && state_q == i2c_pkg::BS_BYTE && qtr_q == 2'd2 && slot_q == BYTE_READ) begin
      rd_data_o <= {rd_data_o[6:0], sda_in};
    end
  end

  // Idle bus keeps its enables low
  assign scl1_oe_o = scl_oe_q && !cmd_q.bus_sel;
  assign sda1_oe_o = sda_oe_q && !cmd_q.bus_sel;
  assign scl2_oe_o = scl_oe_q && cmd_q.bus_sel;
  assign sda2_oe_o = sda_oe_q && cmd_q.bus_sel;

  // Both lines free before the next command may switch buses
  a_idle_released: assert property (@(posedge clk) disable iff (reset_i)
    state_q == i2c_pkg::BS_IDLE |-> !scl_oe_q && !sda_oe_q);

endmodule

// ==== i2c_cmd_fifo.sv ====
`timescale 1ns/1ns

module i2c_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              push_i,
  input  i2c_pkg::i2c_cmd_t cmd_i,
  input  logic              pop_i,
  output i2c_pkg::i2c_cmd_t cmd_o,
  output logic              full_o,
  output logic              empty_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  i2c_pkg::i2c_cmd_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W:0]    count_q;
  logic              wr_en;
  logic              rd_en;

  assign full_o  = (count_q == (PTR_W+1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign wr_en   = push_i && !full_o;
  assign rd_en   = pop_i && !empty_o;
  assign cmd_o   = mem_q[rd_ptr_q];  // Head is visible without a pop

  always_ff @(posedge clk) begin
    if (wr_en) mem_q[wr_ptr_q] <= cmd_i;
  end

  // Pointers wrap on their own with a power of two depth
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
    full_o |-> !push_i);
  a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
    empty_o |-> !pop_i);

endmodule

// ==== i2c_init_sequencer.sv ====
`timescale 1ns/1ns

module i2c_init_sequencer (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                init_start_i,
  input  logic                lost_clock_i,
  input  logic                host_req_valid_i,
  input  i2c_pkg::host_req_e  host_req_i,
  input  logic                fifo_full_i,
  output logic                cmd_push_o,
  output i2c_pkg::i2c_cmd_t   cmd_o,
  input  logic                xfer_done_i,
  input  logic                nack_i,
  input  logic [7:0]          rd_data_i,
  output logic                busy_o,
  output logic                error_o,
  output i2c_pkg::board_cfg_t cfg_o
);

  // Script boundaries in the ROM
  localparam logic [5:0] INIT_FIRST  = 6'd0;
  localparam logic [5:0] RD_FIRST    = 6'd7;   // First EEPROM read
  localparam logic [5:0] INIT_LAST   = 6'd13;
  localparam logic [5:0] C2ON_FIRST  = 6'd14;
  localparam logic [5:0] C2RS_FIRST  = 6'd20;  // Resync is the tail of CLK2_ON
  localparam logic [5:0] C2ON_LAST   = 6'd21;
  localparam logic [5:0] C2OFF_FIRST = 6'd22;
  localparam logic [5:0] C2OFF_LAST  = 6'd23;
  localparam logic [5:0] C1ON_FIRST  = 6'd24;
  localparam logic [5:0] C1ON_LAST   = 6'd29;
  localparam logic [5:0] C1OFF_FIRST = 6'd30;
  localparam logic [5:0] C1OFF_LAST  = 6'd35;

  i2c_pkg::seq_state_e state_q;
  logic [5:0]          idx_q;
  logic [5:0]          last_q;
  logic [5:0]          pending_q;   // Pushed but not yet completed
  logic [5:0]          pending_nxt;
  logic [5:0]          req_first;
  logic [5:0]          req_last;
  logic                req_ok;
  logic [2:0]          rd_slot;
  logic [5:0]          rd_lsb;

  function automatic i2c_pkg::i2c_cmd_t clk_wr(input logic [7:0] ra, input logic [7:0] wd);
    clk_wr = '{op: i2c_pkg::OP_WRITE, bus_sel: 1'b0, dev_addr: i2c_pkg::CLKGEN_ADDR,
               reg_addr: ra, wdata: wd};
  endfunction

  function automatic i2c_pkg::i2c_cmd_t ee_rd(input logic [7:0] ra);
    ee_rd = '{op: i2c_pkg::OP_READ, bus_sel: 1'b1, dev_addr: i2c_pkg::EEPROM_ADDR,
              reg_addr: ra, wdata: 8'h00};
  endfunction

  //////////////////////////////////////////////////////////////
  // Script ROM

  always_comb begin
    case (idx_q)
      6'd0:  cmd_o = clk_wr(8'h17, 8'h04);  // Feedback divider 0x0440
      6'd1:  cmd_o = clk_wr(8'h18, 8'h40);
      6'd2:  cmd_o = clk_wr(8'h1e, 8'he8);  // RC control
      6'd3:  cmd_o = clk_wr(8'h1f, 8'h80);
      6'd4:  cmd_o = clk_wr(8'h2d, 8'h01);  // Output 1 divider
      6'd5:  cmd_o = clk_wr(8'h2e, 8'h10);
      6'd6:  cmd_o = clk_wr(8'h60, 8'h3b);  // Output 1 enable
      6'd7:  cmd_o = ee_rd(8'h8c);          // IP bytes MSB first
      6'd8:  cmd_o = ee_rd(8'h9c);
      6'd9:  cmd_o = ee_rd(8'hac);
      6'd10: cmd_o = ee_rd(8'hbc);
      6'd11: cmd_o = ee_rd(8'hcc);          // MAC suffix
      6'd12: cmd_o = ee_rd(8'hdc);
      6'd13: cmd_o = ee_rd(8'h6c);          // Config byte
      6'd14: cmd_o = clk_wr(8'h62, 8'h3b);  // Clock 2 CMOS at 3.3 V
      6'd15: cmd_o = clk_wr(8'h3d, 8'h01);
      6'd16: cmd_o = clk_wr(8'h3e, 8'h10);
      6'd17: cmd_o = clk_wr(8'h31, 8'h81);
      6'd18: cmd_o = clk_wr(8'h3f, 8'h1f);  // Skew fraction
      6'd19: cmd_o = clk_wr(8'h63, 8'h01);
      6'd20: cmd_o = clk_wr(8'h76, 8'h43);  // Sync reset on
      6'd21: cmd_o = clk_wr(8'h76, 8'h63);  // and off
      6'd22: cmd_o = clk_wr(8'h31, 8'h80);
      6'd23: cmd_o = clk_wr(8'h63, 8'h00);
      6'd24: cmd_o = clk_wr(8'h17, 8'h02);  // Multiplier 0x0220
      6'd25: cmd_o = clk_wr(8'h18, 8'h20);
      6'd26: cmd_o = clk_wr(8'h10, 8'hc0);
      6'd27: cmd_o = clk_wr(8'h13, 8'h03);  // Switch to clock input
      6'd28: cmd_o = clk_wr(8'h10, 8'h44);
      6'd29: cmd_o = clk_wr(8'h21, 8'h0c);
      6'd30: cmd_o = clk_wr(8'h10, 8'hc4);
      6'd31: cmd_o = clk_wr(8'h21, 8'h81);
      6'd32: cmd_o = clk_wr(8'h13, 8'h00);  // Back to crystal
      6'd33: cmd_o = clk_wr(8'h10, 8'h80);
      6'd34: cmd_o = clk_wr(8'h17, 8'h04);
      6'd35: cmd_o = clk_wr(8'h18, 8'h40);
      default: cmd_o = '0;
    endcase
  end

  // Host request decode
  always_comb begin
    req_ok    = 1'b1;
    req_first = C2ON_FIRST;
    req_last  = C2ON_LAST;
    case (host_req_i)
      i2c_pkg::REQ_CLK2_ON: begin
        req_first = C2ON_FIRST;
        req_last  = C2ON_LAST;
      end
      i2c_pkg::REQ_CLK2_RESYNC: begin
        req_first = C2RS_FIRST;
        req_last  = C2ON_LAST;
      end
      i2c_pkg::REQ_CLK2_OFF: begin
        req_first = C2OFF_FIRST;
        req_last  = C2OFF_LAST;
      end
      i2c_pkg::REQ_CLK1_ON: begin
        req_first = C1ON_FIRST;
        req_last  = C1ON_LAST;
      end
      i2c_pkg::REQ_CLK1_OFF: begin
        req_first = C1OFF_FIRST;
        req_last  = C1OFF_LAST;
      end
      default: req_ok = 1'b0;
    endcase
  end

  // Reads wait for an empty pipeline so results land in order
  assign cmd_push_o = (state_q == i2c_pkg::ST_ISSUE) && !fifo_full_i &&
                      (cmd_o.op == i2c_pkg::OP_WRITE || pending_q == 6'd0);
  assign pending_nxt = pending_q + 6'(cmd_push_o) - 6'(xfer_done_i);

  assign rd_slot = 3'(idx_q - RD_FIRST);
  assign rd_lsb  = 6'(8 * (3'd6 - rd_slot));

  //////////////////////////////////////////////////////////////
  // Sequencer FSM

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= i2c_pkg::ST_WAIT_START;
      idx_q     <= '0;
      last_q    <= '0;
      pending_q <= '0;
      busy_o    <= 1'b0;
      error_o   <= 1'b0;
      cfg_o     <= '0;
    end else begin
      pending_q <= pending_nxt;
      if (xfer_done_i && nack_i) error_o <= 1'b1;  // Sticky

      case (state_q)
        i2c_pkg::ST_WAIT_START: begin
          if (init_start_i) begin
            idx_q   <= INIT_FIRST;
            last_q  <= INIT_LAST;
            busy_o  <= 1'b1;
            state_q <= i2c_pkg::ST_ISSUE;
          end
        end
        i2c_pkg::ST_IDLE: begin
          if (lost_clock_i) begin  // Wins over the host
            idx_q   <= C1OFF_FIRST;
            last_q  <= C1OFF_LAST;
            busy_o  <= 1'b1;
            state_q <= i2c_pkg::ST_ISSUE;
          end else if (host_req_valid_i && req_ok) begin
            idx_q   <= req_first;
            last_q  <= req_last;
            busy_o  <= 1'b1;
            state_q <= i2c_pkg::ST_ISSUE;
          end
        end
        i2c_pkg::ST_ISSUE: begin
          if (cmd_push_o) begin
            if (cmd_o.op == i2c_pkg::OP_READ) state_q <= i2c_pkg::ST_READ_WAIT;
            else if (idx_q == last_q) state_q <= i2c_pkg::ST_DRAIN;
            else idx_q <= idx_q + 6'd1;
          end
        end
        i2c_pkg::ST_READ_WAIT: begin
          if (xfer_done_i) begin
            cfg_o[rd_lsb +: 8] <= rd_data_i;
            if (idx_q == last_q) begin
              busy_o  <= 1'b0;
              state_q <= i2c_pkg::ST_IDLE;
            end else begin
              idx_q   <= idx_q + 6'd1;
              state_q <= i2c_pkg::ST_ISSUE;
            end
          end
        end
        i2c_pkg::ST_DRAIN: begin
          if (pending_nxt == 6'd0) begin  // Last write off the bus
            busy_o  <= 1'b0;
            state_q <= i2c_pkg::ST_IDLE;
          end
        end
        default: state_q <= i2c_pkg::ST_IDLE;
      endcase
    end
  end

  // Every completion belongs to an outstanding transfer
  a_done_outstanding: assert property (@(posedge clk) disable iff (reset_i)
    xfer_done_i |-> pending_q != 6'd0);

endmodule

// ==== i2c_patterns.txt ====
// Columns tag(2) reg(2) data(2) hex, one record per line
// Tag 00 init, 01 clk2_on, 02 clk2_off, 03 clk2_resync, 04 clk1_on, 05 clk1_off writes
// Tag e0 EEPROM byte at address, tag a0 script used for the NACK test
e08cc0
e09ca8
e0ac01
e0bc2a
e0cc3e
e0dc71
e06c05
001704
001840
001ee8
001f80
002d01
002e10
00603b
01623b
013d01
013e10
013181
013f1f
016301
017643
017663
023180
026300
037643
037663
041702
041820
0410c0
041303
041044
04210c
0510c4
052181
051300
051080
051704
051840
a00200

// ==== i2c_pkg.sv ====
package i2c_pkg;

  //////////////////////////////////////////////////////////////
  // Opcodes and request selectors

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } i2c_op_e;

  // Host script requests
  typedef enum logic [2:0] {
    REQ_CLK2_ON     = 3'd0,
    REQ_CLK2_OFF    = 3'd1,
    REQ_CLK2_RESYNC = 3'd2,
    REQ_CLK1_ON     = 3'd3,
    REQ_CLK1_OFF    = 3'd4
  } host_req_e;

  //////////////////////////////////////////////////////////////
  // Payload types

  typedef struct packed {
    i2c_op_e    op;
    logic       bus_sel;   // 0 is bus 1, 1 is bus 2
    logic [6:0] dev_addr;
    logic [7:0] reg_addr;
    logic [7:0] wdata;     // Don't care on reads
  } i2c_cmd_t;

  typedef struct packed {
    logic [31:0] static_ip;
    logic [15:0] alt_mac;
    logic [7:0]  eeprom_config;
  } board_cfg_t;

  //////////////////////////////////////////////////////////////
  // FSM states

  typedef enum logic [2:0] {
    ST_WAIT_START,
    ST_IDLE,
    ST_ISSUE,
    ST_READ_WAIT,
    ST_DRAIN
  } seq_state_e;

  typedef enum logic [2:0] {
    BS_IDLE,
    BS_START,
    BS_BYTE,
    BS_ACK,
    BS_RESTART,
    BS_STOP
  } bus_state_e;

  // Device addresses
  localparam logic [6:0] CLKGEN_ADDR = 7'h6a;
  localparam logic [6:0] EEPROM_ADDR = 7'h56;

endpackage

// ==== i2c_subsystem.sv ====
`timescale 1ns/1ns

module i2c_subsystem #(
  parameter int FIFO_DEPTH = 4,
  parameter int SCL_DIV    = 4
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                init_start_i,
  input  logic                lost_clock_i,
  input  logic                host_req_valid_i,
  input  i2c_pkg::host_req_e  host_req_i,
  output logic                busy_o,
  output logic                error_o,
  output i2c_pkg::board_cfg_t cfg_o,
  input  logic                scl1_i,
  input  logic                sda1_i,
  output logic                scl1_oe_o,
  output logic                sda1_oe_o,
  input  logic                scl2_i,
  input  logic                sda2_i,
  output logic                scl2_oe_o,
  output logic                sda2_oe_o
);

  i2c_pkg::i2c_cmd_t seq_cmd;
  i2c_pkg::i2c_cmd_t head_cmd;
  logic              cmd_push;
  logic              cmd_pop;
  logic              fifo_full;
  logic              fifo_empty;
  logic              xfer_done;
  logic              nack;
  logic [7:0]        rd_data;

  // Script producer
  i2c_init_sequencer i_i2c_init_sequencer (
    .clk              (clk),
    .reset_i          (reset_i),
    .init_start_i     (init_start_i),
    .lost_clock_i     (lost_clock_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req_i),
    .fifo_full_i      (fifo_full),
    .cmd_push_o       (cmd_push),
    .cmd_o            (seq_cmd),
    .xfer_done_i      (xfer_done),
    .nack_i           (nack),
    .rd_data_i        (rd_data),
    .busy_o           (busy_o),
    .error_o          (error_o),
    .cfg_o            (cfg_o)
  );

  i2c_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_i2c_cmd_fifo (
    .clk     (clk),
    .reset_i (reset_i),
    .push_i  (cmd_push),
    .cmd_i   (seq_cmd),
    .pop_i   (cmd_pop),
    .cmd_o   (head_cmd),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // Bit level master on both buses
  i2c_bus_master #(
    .SCL_DIV (SCL_DIV)
  ) i_i2c_bus_master (
    .clk         (clk),
    .reset_i     (reset_i),
    .empty_i     (fifo_empty),
    .cmd_i       (head_cmd),
    .pop_o       (cmd_pop),
    .xfer_done_o (xfer_done),
    .nack_o      (nack),
    .rd_data_o   (rd_data),
    .scl1_i      (scl1_i),
    .sda1_i      (sda1_i),
    .scl2_i      (scl2_i),
    .sda2_i      (sda2_i),
    .scl1_oe_o   (scl1_oe_o),
    .sda1_oe_o   (sda1_oe_o),
    .scl2_oe_o   (scl2_oe_o),
    .sda2_oe_o   (sda2_oe_o)
  );

endmodule

// ==== i2c_target_model.sv ====
`timescale 1ns/1ns

module i2c_target_model #(
  parameter logic [6:0] DEV_ADDR = 7'h00,
  parameter logic       BUS_SEL  = 1'b0
) (
  input  logic scl_i,
  input  logic sda_i,
  input  logic ack_enable_i,
  output logic sda_oe_o
);

  typedef enum logic [2:0] {PH_IDLE, PH_RX, PH_ACK, PH_TX, PH_MACK} phase_e;

  phase_e            phase;
  int                bit_cnt;
  int                byte_idx;
  logic [7:0]        shreg;
  logic [7:0]        reg_ptr;
  logic [7:0]        tx_byte;
  logic              addressed;
  logic              rd_mode;
  logic              acked;
  logic              drive;
  logic              scl_q;
  logic              sda_q;
  logic [7:0]        mem [256];
  i2c_pkg::i2c_cmd_t wr_log [64];
  int                log_cnt;

  initial begin
    sda_oe_o = 1'b0;
    phase    = PH_IDLE;
    log_cnt  = 0;
    scl_q    = 1'b1;
    sda_q    = 1'b1;
    for (int a = 0; a < 256; a++) mem[a] = 8'(a) ^ 8'ha5;  // Fill differs per address
  end

  task automatic clear_log();
    log_cnt = 0;
  endtask

  task automatic load_byte(input logic [7:0] addr, input logic [7:0] data);
    mem[addr] = data;
  endtask

  //////////////////////////////////////////////////////////////
  // Bus event decoder

  always @(scl_i or sda_i) begin
    if (scl_i === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda_i === 1'b0) begin
      phase    = PH_RX;  // START or repeated START
      bit_cnt  = 0;
      byte_idx = 0;
      sda_oe_o = 1'b0;
    end else if (scl_i === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda_i === 1'b1) begin
      phase    = PH_IDLE;  // STOP
      sda_oe_o = 1'b0;
    end else if (scl_q === 1'b0 && scl_i === 1'b1) begin
      case (phase)
        PH_RX: begin
          shreg   = {shreg[6:0], sda_i};
          bit_cnt = bit_cnt + 1;
        end
        PH_TX:   bit_cnt = bit_cnt + 1;
        default: ;
      endcase
    end else if (scl_q === 1'b1 && scl_i === 1'b0) begin
      drive = 1'b0;
      case (phase)
        PH_RX: begin
          if (bit_cnt == 8) begin
            if (byte_idx == 0) begin
              addressed = (shreg[7:1] == DEV_ADDR);
              rd_mode   = shreg[0];
            end else if (byte_idx == 1 && !rd_mode) begin
              reg_ptr = shreg;
            end else if (byte_idx == 2 && !rd_mode && addressed && ack_enable_i &&
                         log_cnt < 64) begin
              wr_log[log_cnt] = '{op: i2c_pkg::OP_WRITE, bus_sel: BUS_SEL,
                                  dev_addr: DEV_ADDR, reg_addr: reg_ptr, wdata: shreg};
              log_cnt = log_cnt + 1;
            end
            byte_idx = byte_idx + 1;
            acked    = addressed && ack_enable_i;
            drive    = acked;
            phase    = PH_ACK;
          end
        end
        PH_ACK: begin
          bit_cnt = 0;
          if (!acked) begin
            phase = PH_IDLE;
          end else if (rd_mode) begin
            tx_byte = mem[reg_ptr];
            drive   = !tx_byte[7];  // First data bit right after our ACK
            phase   = PH_TX;
          end else begin
            phase = PH_RX;
          end
        end
        PH_TX: begin
          if (bit_cnt == 8) phase = PH_MACK;
          else drive = !tx_byte[7 - bit_cnt];
        end
        PH_MACK: phase = PH_IDLE;  // One byte per read
        default: ;
      endcase
      sda_oe_o = drive;
    end
    scl_q = scl_i;
    sda_q = sda_i;
  end

endmodule

// ==== sources.f ====
i2c_pkg.sv
i2c_cmd_fifo.sv
i2c_init_sequencer.sv
i2c_bus_master.sv
i2c_subsystem.sv
tb_clock_gen.sv
i2c_target_model.sv
tb_i2c_subsystem.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset_o
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_o = 1'b0;  // Released just after the edge
  end

endmodule

// ==== tb_i2c_subsystem.sv ====
`timescale 1ns/1ns

module tb_i2c_subsystem;

  localparam int TIMEOUT   = 20000;
  localparam int DRIVE_DLY = 1;
  localparam int MAX_WR    = 16;

  logic                clk;
  logic                reset_i;
  logic                init_start_i;
  logic                lost_clock_i;
  logic                host_req_valid_i;
  i2c_pkg::host_req_e  host_req_i;
  logic                busy_o;
  logic                error_o;
  i2c_pkg::board_cfg_t cfg_o;
  logic                scl1_oe;
  logic                sda1_oe;
  logic                scl2_oe;
  logic                sda2_oe;
  logic                tgt1_sda_oe;
  logic                tgt2_sda_oe;
  logic                clk_ack_en;
  logic                ee_ack_en;
  wire                 scl1;
  wire                 sda1;
  wire                 scl2;
  wire                 sda2;

  logic [23:0]         pat_mem [128];
  i2c_pkg::i2c_cmd_t   exp_wr [6][MAX_WR];
  int                  exp_cnt [6];
  i2c_pkg::board_cfg_t exp_cfg;
  int                  nack_script;
  int                  mismatch_errs;
  int                  other_errs;
  int                  seed;
  string               script_names [6] = '{"init", "clk2_on", "clk2_off", "clk2_resync",
                                            "clk1_on", "clk1_off"};

  // Open drain, pulled high unless someone pulls low
  assign scl1 = !scl1_oe;
  assign sda1 = !(sda1_oe || tgt1_sda_oe);
  assign scl2 = !scl2_oe;
  assign sda2 = !(sda2_oe || tgt2_sda_oe);

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) i_tb_clock_gen (.clk(clk), .reset_o(reset_i));

  i2c_subsystem #(
    .FIFO_DEPTH (4),
    .SCL_DIV    (2)
  ) i_i2c_subsystem (
    .clk              (clk),
    .reset_i          (reset_i),
    .init_start_i     (init_start_i),
    .lost_clock_i     (lost_clock_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req_i),
    .busy_o           (busy_o),
    .error_o          (error_o),
    .cfg_o            (cfg_o),
    .scl1_i           (scl1),
    .sda1_i           (sda1),
    .scl1_oe_o        (scl1_oe),
    .sda1_oe_o        (sda1_oe),
    .scl2_i           (scl2),
    .sda2_i           (sda2),
    .scl2_oe_o        (scl2_oe),
    .sda2_oe_o        (sda2_oe)
  );

  i2c_target_model #(.DEV_ADDR(i2c_pkg::CLKGEN_ADDR), .BUS_SEL(1'b0)) i_clk_target (
    .scl_i (scl1), .sda_i (sda1), .ack_enable_i (clk_ack_en), .sda_oe_o (tgt1_sda_oe)
  );

  i2c_target_model #(.DEV_ADDR(i2c_pkg::EEPROM_ADDR), .BUS_SEL(1'b1)) i_ee_target (
    .scl_i (scl2), .sda_i (sda2), .ack_enable_i (ee_ack_en), .sda_oe_o (tgt2_sda_oe)
  );

  //////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_cmd(input string name, input i2c_pkg::i2c_cmd_t exp,
                           input i2c_pkg::i2c_cmd_t act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_cfg(input string name, input i2c_pkg::board_cfg_t exp,
                           input i2c_pkg::board_cfg_t act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      mismatch_errs++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;  // Drive and sample away from the edge
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (reset_i !== 1'b0 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (reset_i !== 1'b0) begin
      other_errs++;
      $display("Reset was never released");
    end
  endtask

  task automatic wait_busy(input string name, input logic level);
    int n;
    n = 0;
    while (busy_o !== level && n < TIMEOUT) begin
      step();
      n++;
    end
    if (busy_o !== level) begin
      other_errs++;
      $display("Timeout in %s: busy_o did not go to %b within %0d cycles", name, level, TIMEOUT);
    end
  endtask

  task automatic send_request(input i2c_pkg::host_req_e req);
    host_req_i       = req;
    host_req_valid_i = 1'b1;
    step();
    host_req_valid_i = 1'b0;
  endtask

  function automatic i2c_pkg::host_req_e req_for_script(input int s);
    case (s)
      2:       req_for_script = i2c_pkg::REQ_CLK2_OFF;
      3:       req_for_script = i2c_pkg::REQ_CLK2_RESYNC;
      4:       req_for_script = i2c_pkg::REQ_CLK1_ON;
      5:       req_for_script = i2c_pkg::REQ_CLK1_OFF;
      default: req_for_script = i2c_pkg::REQ_CLK2_ON;
    endcase
  endfunction

  // Records are tag, register or address, data
  task automatic load_patterns();
    int         i;
    logic [7:0] tag;
    logic [7:0] ra;
    logic [7:0] d;
    for (i = 0; i < 128; i++) pat_mem[i] = '1;
    for (i = 0; i < 6; i++) exp_cnt[i] = 0;
    exp_cfg     = '0;
    nack_script = 2;
    $readmemh("i2c_patterns.txt", pat_mem);
    i = 0;
    while (i < 128 && pat_mem[i][23:16] != 8'hff) begin
      {tag, ra, d} = pat_mem[i];
      if (tag < 8'd6 && exp_cnt[tag] < MAX_WR) begin
        exp_wr[tag][exp_cnt[tag]] = '{op: i2c_pkg::OP_WRITE, bus_sel: 1'b0,
                                      dev_addr: i2c_pkg::CLKGEN_ADDR, reg_addr: ra, wdata: d};
        exp_cnt[tag]++;
      end else if (tag == 8'he0) begin
        i_ee_target.load_byte(ra, d);
        case (ra)  // IP and MAC most significant byte first
          8'h8c:   exp_cfg.static_ip[31:24] = d;
          8'h9c:   exp_cfg.static_ip[23:16] = d;
          8'hac:   exp_cfg.static_ip[15:8]  = d;
          8'hbc:   exp_cfg.static_ip[7:0]   = d;
          8'hcc:   exp_cfg.alt_mac[15:8]    = d;
          8'hdc:   exp_cfg.alt_mac[7:0]     = d;
          8'h6c:   exp_cfg.eeprom_config    = d;
          default: ;
        endcase
      end else if (tag == 8'ha0) begin
        nack_script = int'(ra);
      end
      i++;
    end
  endtask

  task automatic compare_log(input string name, input int s);
    int i;
    int n;
    n = i_clk_target.log_cnt;
    check_count({name, "_count"}, exp_cnt[s], n);
    for (i = 0; i < exp_cnt[s] && i < n; i++) begin
      check_cmd($sformatf("%s[%0d]", name, i), exp_wr[s][i], i_clk_target.wr_log[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int s;
    int gap;
    init_start_i     = 1'b0;
    lost_clock_i     = 1'b0;
    host_req_valid_i = 1'b0;
    host_req_i       = i2c_pkg::REQ_CLK2_ON;
    clk_ack_en       = 1'b1;
    ee_ack_en        = 1'b1;
    mismatch_errs    = 0;
    other_errs       = 0;
    seed             = 32'h244b;

    wait_reset_release();
    load_patterns();

    // Dropped before init
    send_request(i2c_pkg::REQ_CLK2_ON);
    idle_cycles(20);
    check_flag("pre_init_busy", 1'b0, busy_o);
    check_count("pre_init_log", 0, i_clk_target.log_cnt);

    init_start_i = 1'b1;
    wait_busy("init", 1'b1);
    send_request(i2c_pkg::REQ_CLK1_ON);  // Busy, must be ignored
    wait_busy("init", 1'b0);
    compare_log("init", 0);
    check_cfg("init_cfg", exp_cfg, cfg_o);
    check_flag("init_error", 1'b0, error_o);

    for (s = 1; s <= 5; s++) begin
      gap = 1 + ($unsigned($random(seed)) % 16);
      idle_cycles(gap);
      i_clk_target.clear_log();
      send_request(req_for_script(s));
      wait_busy(script_names[s], 1'b1);
      wait_busy(script_names[s], 1'b0);
      compare_log(script_names[s], s);
    end

    // Lost clock runs CLK1_OFF on its own
    idle_cycles(5);
    i_clk_target.clear_log();
    lost_clock_i = 1'b1;
    wait_busy("lost_clock", 1'b1);
    lost_clock_i = 1'b0;
    wait_busy("lost_clock", 1'b0);
    compare_log("lost_clock", 5);

    check_flag("pre_nack_error", 1'b0, error_o);
    idle_cycles(5);
    i_clk_target.clear_log();
    clk_ack_en = 1'b0;
    send_request(req_for_script(nack_script));
    wait_busy("nack", 1'b1);
    wait_busy("nack", 1'b0);
    check_flag("nack_error", 1'b1, error_o);
    check_count("nack_log", 0, i_clk_target.log_cnt);
    clk_ack_en = 1'b1;

    $display("Run finished with %0d mismatches and %0d other errors", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
